// ==== compile.f ====
common/i2c_pkg.sv
i2c_master/i2c_scl_gen.sv
i2c_master/i2c_byte_fsm.sv
src/apb_i2c_regs.sv
src/i2c_ctrl_top.sv
dv/i2c_target_model.sv
dv/i2c_ctrl_assert.sv
dv/tb_i2c_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the I2C master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --top-module tb_i2c_ctrl \
    --Mdir obj_dir -o sim_tb \
    -f compile.f

./obj_dir/sim_tb

// ==== dv/i2c_stim.txt ====
# name target rw tx_data exp_rx exp_nack  (hex fields)
# exp_rx is RXDATA after the transfer; writes and NACKs keep it
rd_reset   50 1 00 A5 0
wr_3c      50 0 3C A5 0
rd_3c      50 1 00 3C 0
wr_bad     23 0 55 3C 1
rd_bad     51 1 00 3C 1
wr_c3      50 0 C3 3C 0
rd_c3      50 1 00 C3 0
wr_00      50 0 00 C3 0
rd_00      50 1 00 00 0
wr_ff      50 0 FF 00 0
rd_ff      50 1 00 FF 0
rd_ff_2    50 1 00 FF 0
rd_bad_7f  7F 1 00 FF 1
wr_5a      50 0 5A FF 0
rd_5a      50 1 00 5A 0

// ==== dv/tb_i2c_ctrl.sv ====
/*
 * Testbench for the APB I2C master: clock, reset, APB tasks,
 * stim-file transactions, register and busy-start checks, timeout
 */
`timescale 1ns/1ps

module tb_i2c_ctrl;

    localparam int CLK_DIV = 2;

    logic              clk;
    logic              rst;
    i2c_pkg::apb_req_t apb_req;
    i2c_pkg::apb_rsp_t apb_rsp;
    logic              scl_oe;
    logic              sda_oe_m;
    logic              sda_oe_t;
    wire               scl = ~scl_oe;                 // Wired-AND bus
    wire               sda = ~(sda_oe_m | sda_oe_t);
    int                cycle_limit;
    int                cycles;

    i2c_ctrl_top #(.CLK_DIV(CLK_DIV)) UUT (
        .clk (clk), .rst (rst), .apb_req (apb_req), .apb_rsp (apb_rsp),
        .scl_oe (scl_oe), .sda_oe (sda_oe_m), .sda_in (sda)
    );

    i2c_target_model #(.ADDR(7'h50), .RESET_BYTE(8'hA5)) u_target (
        .clk (clk), .rst (rst), .scl (scl), .sda (sda), .sda_oe (sda_oe_t)
    );

    always #10 clk = ~clk;

    task automatic check(input string name, input logic [31:0] exp_v,
                         input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v);
            $display("Simulation failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic apb_access(input logic wr, input i2c_pkg::apb_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(negedge clk);
        apb_req.penable = 1'b1;
        #5;  // Mid access cycle
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check("pready", 32'd1, {31'd0, apb_rsp.pready});
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic wait_done();
        logic [31:0] st;
        logic        err;
        do apb_access(1'b0, i2c_pkg::REG_STATUS, '0, st, err);
        while (!st[1] || st[0]);
    endtask

    task automatic start_cmd(input logic [6:0] tgt, input logic rw, input logic [7:0] tx);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, i2c_pkg::REG_TXDATA, {24'd0, tx}, rd, err);
        check("txdata_write_err", 32'd0, {31'd0, err});
        apb_access(1'b1, i2c_pkg::REG_CTRL, {17'd0, tgt, 6'd0, rw, 1'b1}, rd, err);
        check("ctrl_write_err", 32'd0, {31'd0, err});
    endtask

    // Stops the run if the DUT stalls
    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: transfers did not finish within %0d cycles", cycle_limit);
        $display("Simulation failed");
        $fatal(1, "Timeout");
    end

    initial begin
        int             fd;
        int             n_lines;
        string          line;
        logic [127:0]   name_bits;
        string          nm;
        logic [6:0]     tgt;
        logic           rw;
        logic [7:0]     tx;
        logic [7:0]     exp_rx;
        logic           exp_nack;
        logic [7:0]     last_wr;   // Byte the target should hold
        logic [31:0]    rd;
        logic           err;
        clk         = 1'b0;
        rst         = 1'b1;
        apb_req     = '0;
        cycle_limit = 0;
        n_lines     = 0;
        last_wr     = 8'hA5;
        fd = $fopen("dv/i2c_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file dv/i2c_stim.txt");
            $display("Simulation failed");
            $fatal(1, "No stimulus");
        end
        while ($fgets(line, fd) > 0)
            if (line.len() > 1 && line[0] != "#") n_lines++;
        $fclose(fd);
        cycle_limit = (n_lines + 3) * 4 * CLK_DIV * 24 + 200;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset state and register errors
        apb_access(1'b0, i2c_pkg::REG_STATUS, '0, rd, err);
        check("status_after_reset", 32'd0, rd);
        check("bus_idle", 32'd0, {30'd0, scl_oe, sda_oe_m});
        apb_access(1'b0, 8'h10, '0, rd, err);
        check("bad_offset_err", 32'd1, {31'd0, err});
        apb_access(1'b1, i2c_pkg::REG_STATUS, 32'hFFFF_FFFF, rd, err);
        check("status_write_err", 32'd1, {31'd0, err});
        apb_access(1'b1, i2c_pkg::REG_RXDATA, 32'h0000_00FF, rd, err);
        check("rxdata_write_err", 32'd1, {31'd0, err});
        apb_access(1'b0, i2c_pkg::REG_STATUS, '0, rd, err);
        check("status_unchanged", 32'd0, rd);
        apb_access(1'b0, i2c_pkg::REG_RXDATA, '0, rd, err);
        check("rxdata_unchanged", 32'd0, rd);

        fd = $fopen("dv/i2c_stim.txt", "r");
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%s %h %h %h %h %h", name_bits, tgt, rw, tx,
                            exp_rx, exp_nack) != 6) begin
                    $display("Malformed stimulus line: %s", line);
                    $display("Simulation failed");
                    $fatal(1, "Bad stimulus");
                end
                nm = $sformatf("%0s", name_bits);
                start_cmd(tgt, rw, tx);
                wait_done();
                apb_access(1'b0, i2c_pkg::REG_STATUS, '0, rd, err);
                check({nm, "_status"}, {29'd0, exp_nack, 2'b10}, rd);
                apb_access(1'b0, i2c_pkg::REG_RXDATA, '0, rd, err);
                check({nm, "_rx"}, {24'd0, exp_rx}, rd);
                if (!rw && !exp_nack) last_wr = tx;
            end
        end
        $fclose(fd);

        // Start written mid-transfer must be dropped
        last_wr = ~last_wr;  // Read below must then change RXDATA
        start_cmd(7'h50, 1'b0, last_wr);
        wait_done();
        start_cmd(7'h50, 1'b1, 8'h00);
        do apb_access(1'b0, i2c_pkg::REG_STATUS, '0, rd, err);
        while (!rd[0]);
        apb_access(1'b1, i2c_pkg::REG_CTRL, {17'd0, 7'h23, 6'd0, 1'b0, 1'b1}, rd, err);
        wait_done();
        apb_access(1'b0, i2c_pkg::REG_RXDATA, '0, rd, err);
        check("busy_start_rx", {24'd0, last_wr}, rd);
        repeat (100) @(negedge clk);
        apb_access(1'b0, i2c_pkg::REG_STATUS, '0, rd, err);
        check("busy_start_status", 32'd2, rd);
        check("busy_start_bus", 32'd0, {30'd0, scl_oe, sda_oe_m});

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== dv/i2c_ctrl_assert.sv ====
/*
 * Concurrent checks on the byte FSM bus outputs and handshakes
 */
`timescale 1ns/1ps

module i2c_ctrl_assert (
    input logic clk,
    input logic rst,
    input logic scl_oe,
    input logic sda_oe,
    input logic run,
    input logic busy,
    input logic cmd_valid,
    input logic done_pulse
);

    // SDA moves under SCL low, START entry and STOP release aside
    sda_stable_high: assert property (@(posedge clk) disable iff (rst)
        $changed(sda_oe) |-> $past(scl_oe) || !$past(run) || done_pulse)
        else $error("SDA changed while SCL high outside START/STOP");

    busy_needs_cmd: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(cmd_valid))
        else $error("busy rose without cmd_valid");

    done_then_idle: assert property (@(posedge clk) disable iff (rst)
        done_pulse |=> !busy)
        else $error("busy still high after done_pulse");

endmodule

bind i2c_byte_fsm i2c_ctrl_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .scl_oe     (scl_oe),
    .sda_oe     (sda_oe),
    .run        (run),
    .busy       (busy),
    .cmd_valid  (cmd_valid),
    .done_pulse (done_pulse)
);

// ==== dv/i2c_target_model.sv ====
/*
 * Behavioral I2C target at one fixed address holding one byte,
 * sampled on the system clock, answers writes and reads
 */
`timescale 1ns/1ps

module i2c_target_model #(
    parameter i2c_pkg::i2c_addr_t ADDR       = 7'h50,
    parameter i2c_pkg::byte_t     RESET_BYTE = 8'hA5
) (
    input  logic clk,
    input  logic rst,
    input  logic scl,      // Resolved bus lines
    input  logic sda,
    output logic sda_oe    // Pull SDA low
);

    localparam int T_IDLE  = 0;
    localparam int T_ADDR  = 1;
    localparam int T_AACK  = 2;  // ACK bit starts at next fall
    localparam int T_AACK2 = 3;  // ACK bit ends at next fall
    localparam int T_WRITE = 4;
    localparam int T_WACK  = 5;
    localparam int T_WACK2 = 6;
    localparam int T_READ  = 7;
    localparam int T_MACK  = 8;  // Master ACK and STOP follow

    int             phase;
    logic           scl_q;
    logic           sda_q;
    logic [2:0]     cnt;     // Bits seen in current byte
    i2c_pkg::byte_t shreg;
    i2c_pkg::byte_t held;    // Byte returned on reads
    logic           rw_q;

    always_ff @(posedge clk or posedge rst) begin
        logic [7:0] nxt;
        if (rst) begin
            phase  <= T_IDLE;
            scl_q  <= 1'b1;
            sda_q  <= 1'b1;
            cnt    <= '0;
            shreg  <= '0;
            held   <= RESET_BYTE;
            rw_q   <= 1'b0;
            sda_oe <= 1'b0;
        end else begin
            nxt   = {shreg[6:0], sda};
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda) begin
                phase  <= T_ADDR;  // START
                cnt    <= '0;
                sda_oe <= 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin
                phase  <= T_IDLE;  // STOP
                sda_oe <= 1'b0;
            end else if (scl && !scl_q) begin
                case (phase)  // Sample on rising SCL
                    T_ADDR: begin
                        shreg <= nxt;
                        cnt   <= cnt + 3'd1;
                        if (cnt == 3'd7) begin
                            rw_q  <= nxt[0];
                            phase <= (nxt[7:1] == ADDR) ? T_AACK : T_IDLE;
                        end
                    end
                    T_WRITE: begin
                        shreg <= nxt;
                        cnt   <= cnt + 3'd1;
                        if (cnt == 3'd7) begin
                            held  <= nxt;  // Keep last written byte
                            phase <= T_WACK;
                        end
                    end
                    T_READ: begin
                        cnt <= cnt + 3'd1;
                        if (cnt == 3'd7) phase <= T_MACK;
                    end
                    default: ;
                endcase
            end else if (!scl && scl_q) begin
                case (phase)  // Drive on falling SCL
                    T_AACK: begin
                        sda_oe <= 1'b1;
                        phase  <= T_AACK2;
                    end
                    T_AACK2: begin
                        cnt <= '0;
                        if (rw_q) begin
                            sda_oe <= ~held[7];  // First read bit
                            phase  <= T_READ;
                        end else begin
                            sda_oe <= 1'b0;
                            phase  <= T_WRITE;
                        end
                    end
                    T_READ: sda_oe <= ~held[3'd7 - cnt];
                    T_WACK: begin
                        sda_oe <= 1'b1;
                        phase  <= T_WACK2;
                    end
                    T_WACK2: begin
                        sda_oe <= 1'b0;
                        phase  <= T_IDLE;
                    end
                    T_MACK: sda_oe <= 1'b0;  // Let master ACK
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== src/i2c_ctrl_top.sv ====
/*
 * APB I2C master top: register block, SCL generator and byte FSM
 */
`timescale 1ns/1ps

module i2c_ctrl_top #(
    parameter int unsigned CLK_DIV = 4  // clk cycles per SCL quarter
) (
    input  logic               clk,
    input  logic               rst,
    input  i2c_pkg::apb_req_t  apb_req,
    output i2c_pkg::apb_rsp_t  apb_rsp,
    output logic               scl_oe,   // Pull SCL low
    output logic               sda_oe,   // Pull SDA low
    input  logic               sda_in
);

    i2c_pkg::i2c_cmd_t    cmd;
    logic                 cmd_valid;
    logic                 busy;
    logic                 done_pulse;
    i2c_pkg::i2c_result_t result;
    logic                 run;
    logic                 scl_low;
    logic                 drive_en;
    logic                 sample_en;

    apb_i2c_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .busy       (busy),
        .done_pulse (done_pulse),
        .result     (result)
    );

    i2c_scl_gen #(
        .CLK_DIV (CLK_DIV)
    ) u_scl_gen (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .scl_low   (scl_low),
        .drive_en  (drive_en),
        .sample_en (sample_en)
    );

    i2c_byte_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .scl_low    (scl_low),
        .drive_en   (drive_en),
        .sample_en  (sample_en),
        .sda_in     (sda_in),
        .run        (run),
        .busy       (busy),
        .done_pulse (done_pulse),
        .result     (result),
        .scl_oe     (scl_oe),
        .sda_oe     (sda_oe)
    );

endmodule

// ==== src/apb_i2c_regs.sv ====
/*
 * APB register block: CTRL, TXDATA, RXDATA and STATUS decode,
 * start pulse generation and sticky done/nack status
 */
`timescale 1ns/1ps

module apb_i2c_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  i2c_pkg::apb_req_t     apb_req,
    output i2c_pkg::apb_rsp_t     apb_rsp,
    output i2c_pkg::i2c_cmd_t     cmd,
    output logic                  cmd_valid,
    input  logic                  busy,
    input  logic                  done_pulse,
    input  i2c_pkg::i2c_result_t  result
);

    logic              access;      // APB access cycle
    logic              hit_ctrl;
    logic              hit_tx;
    logic              hit_rx;
    logic              hit_status;
    logic              wr_ok;       // Writable offset
    logic              rd_ok;       // Readable offset
    logic              wr_en;
    logic [31:0]       rdata;

    i2c_pkg::i2c_addr_t ctrl_target;
    logic               ctrl_rw;
    i2c_pkg::byte_t     tx_q;
    i2c_pkg::byte_t     rx_q;       // Last received byte
    logic               done_q;     // Sticky until next accept
    logic               nack_q;

    assign access     = apb_req.psel && apb_req.penable;
    assign hit_ctrl   = (apb_req.paddr == i2c_pkg::REG_CTRL);
    assign hit_tx     = (apb_req.paddr == i2c_pkg::REG_TXDATA);
    assign hit_rx     = (apb_req.paddr == i2c_pkg::REG_RXDATA);
    assign hit_status = (apb_req.paddr == i2c_pkg::REG_STATUS);
    assign wr_ok      = hit_ctrl || hit_tx;
    assign rd_ok      = wr_ok || hit_rx || hit_status;
    assign wr_en      = access && apb_req.pwrite && wr_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_target <= '0;
            ctrl_rw     <= 1'b0;
            tx_q        <= '0;
            cmd_valid   <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (wr_en && hit_ctrl) begin
                ctrl_target <= apb_req.pwdata[14:8];
                ctrl_rw     <= apb_req.pwdata[1];
                cmd_valid   <= apb_req.pwdata[0] && !busy;  // Drop start while busy
            end
            if (wr_en && hit_tx) tx_q <= apb_req.pwdata[7:0];
        end
    end

    // Status capture from FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_q   <= '0;
            done_q <= 1'b0;
            nack_q <= 1'b0;
        end else if (done_pulse) begin
            rx_q   <= result.rx_data;
            nack_q <= result.nack;
            done_q <= 1'b1;
        end else if (cmd_valid) begin
            done_q <= 1'b0;  // Command accepted
            nack_q <= 1'b0;
        end
    end

    always_comb begin
        rdata = '0;
        if (hit_ctrl) begin
            rdata[14:8] = ctrl_target;
            rdata[1]    = ctrl_rw;  // start reads 0
        end else if (hit_tx) begin
            rdata[7:0] = tx_q;
        end else if (hit_rx) begin
            rdata[7:0] = rx_q;
        end else if (hit_status) begin
            rdata[2:0] = {nack_q, done_q, busy};
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;  // No wait states
    assign apb_rsp.pslverr = access && (apb_req.pwrite ? !wr_ok : !rd_ok);

    assign cmd.target  = ctrl_target;
    assign cmd.rw      = ctrl_rw;
    assign cmd.tx_data = tx_q;

endmodule

// ==== i2c_master/i2c_byte_fsm.sv ====
/*
 * I2C transaction FSM: START, address + rw byte, ACK check, one data
 * byte written or read, master ACK and STOP; SDA input synchronizer
 */
`timescale 1ns/1ps

module i2c_byte_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  i2c_pkg::i2c_cmd_t     cmd,
    input  logic                  cmd_valid,
    input  logic                  scl_low,
    input  logic                  drive_en,
    input  logic                  sample_en,
    input  logic                  sda_in,
    output logic                  run,
    output logic                  busy,
    output logic                  done_pulse,
    output i2c_pkg::i2c_result_t  result,
    output logic                  scl_oe,
    output logic                  sda_oe
);

    typedef enum logic [3:0] {
        IDLE,        // Bus free, waiting for a command
        START,       // SDA low, SCL released
        ADDR,        // Address + rw, MSB first
        ADDR_ACK,    // Target ACK after address
        WRITE,       // Data byte out
        WRITE_ACK,   // Target ACK after data
        READ,        // Data byte in
        MASTER_ACK,  // Master ACKs the read byte
        STOP         // SDA low, then released with SCL high
    } master_state_t;

    master_state_t state;

    logic          sda_meta;  // Synchronizer stage 1
    logic          sda_sync;  // Synchronizer stage 2
    logic [2:0]    bit_cnt;   // Bit index, counts down
    i2c_pkg::byte_t shift_q;  // Out or in shift register
    i2c_pkg::byte_t tx_byte;  // Data byte for WRITE
    logic          rw_q;      // 1 = read transfer

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sda_meta <= 1'b1;  // Idle bus reads high
            sda_sync <= 1'b1;
        end else begin
            sda_meta <= sda_in;
            sda_sync <= sda_meta;
        end
    end

    // Main FSM steps on sample_en and drives SDA on drive_en
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            run        <= 1'b0;
            sda_oe     <= 1'b0;
            done_pulse <= 1'b0;
            bit_cnt    <= '0;
            result     <= '0;
        end else begin
            done_pulse <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        state       <= START;
                        run         <= 1'b1;
                        sda_oe      <= 1'b1;  // SDA falls while SCL high
                        bit_cnt     <= 3'd7;
                        result.nack <= 1'b0;
                    end
                end
                START: begin
                    if (sample_en) state <= ADDR;  // SCL stays up until quarter 0
                end
                ADDR: begin
                    if (drive_en) sda_oe <= ~shift_q[7];  // Pull low for a 0
                    if (sample_en) begin
                        if (bit_cnt == 3'd0) state <= ADDR_ACK;
                        else bit_cnt <= bit_cnt - 3'd1;
                    end
                end
                ADDR_ACK: begin
                    if (drive_en) sda_oe <= 1'b0;  // Hand SDA to target
                    if (sample_en) begin
                        if (sda_sync) begin
                            result.nack <= 1'b1;  // No target at address
                            state       <= STOP;
                        end else begin
                            bit_cnt <= 3'd7;
                            state   <= rw_q ? READ : WRITE;
                        end
                    end
                end
                WRITE: begin
                    if (drive_en) sda_oe <= ~shift_q[7];
                    if (sample_en) begin
                        if (bit_cnt == 3'd0) state <= WRITE_ACK;
                        else bit_cnt <= bit_cnt - 3'd1;
                    end
                end
                WRITE_ACK: begin
                    if (drive_en) sda_oe <= 1'b0;
                    if (sample_en) begin
                        result.nack <= sda_sync;
                        state       <= STOP;
                    end
                end
                READ: begin
                    if (drive_en) sda_oe <= 1'b0;  // Target drives data
                    if (sample_en) begin
                        if (bit_cnt == 3'd0) begin
                            result.rx_data <= {shift_q[6:0], sda_sync};
                            state          <= MASTER_ACK;
                        end else begin
                            bit_cnt <= bit_cnt - 3'd1;
                        end
                    end
                end
                MASTER_ACK: begin
                    if (drive_en) sda_oe <= 1'b1;  // ACK the byte
                    if (sample_en) state <= STOP;
                end
                STOP: begin
                    if (drive_en) sda_oe <= 1'b1;  // Low under SCL low
                    if (sample_en) begin
                        sda_oe     <= 1'b0;  // SDA rises with SCL high
                        run        <= 1'b0;
                        done_pulse <= 1'b1;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Command latch and shift register
    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_valid) begin
            shift_q <= {cmd.target, cmd.rw};
            tx_byte <= cmd.tx_data;
            rw_q    <= cmd.rw;
        end else if (drive_en && (state == ADDR || state == WRITE)) begin
            shift_q <= {shift_q[6:0], 1'b0};  // MSB first
        end else if (sample_en && state == ADDR_ACK) begin
            shift_q <= tx_byte;  // Preload data byte
        end else if (sample_en && state == READ) begin
            shift_q <= {shift_q[6:0], sda_sync};
        end
    end

    assign busy = (state != IDLE);

    // SCL held released through START
    assign scl_oe = run && scl_low && (state != START);

endmodule

// ==== i2c_master/i2c_scl_gen.sv ====
/*
 * SCL timing generator: quarter-period counter, SCL low/high waveform
 * and one-cycle drive and sample enables for the byte FSM
 */
`timescale 1ns/1ps

module i2c_scl_gen #(
    parameter int unsigned CLK_DIV = 4  // clk cycles per SCL quarter
) (
    input  logic clk,
    input  logic rst,
    input  logic run,        // High from START to STOP
    output logic scl_low,    // Pull SCL low
    output logic drive_en,   // Start of quarter 0
    output logic sample_en   // Start of quarter 3
);

    localparam int PW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [PW-1:0] PHASE_LAST = PW'(CLK_DIV - 1);

    localparam logic [1:0] Q_DRIVE  = 2'd0;  // SCL low, SDA may change
    localparam logic [1:0] Q_SAMPLE = 2'd3;  // SCL high, SDA stable

    logic [PW-1:0] phase;    // clk count inside a quarter
    logic [1:0]    quarter;  // Quarter of the current bit
    logic          q_start;  // First clk of any quarter

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= '0;
            quarter <= '0;
        end else if (!run) begin
            phase   <= '0;  // Park at start of quarter 0
            quarter <= '0;
        end else if (phase == PHASE_LAST) begin
            phase   <= '0;
            quarter <= quarter + 2'd1;  // Wraps to next bit
        end else begin
            phase <= phase + 1'b1;
        end
    end

    assign q_start   = run && (phase == '0);
    assign drive_en  = q_start && (quarter == Q_DRIVE);
    assign sample_en = q_start && (quarter == Q_SAMPLE);

    // Quarters 0 and 1 low, 2 and 3 high; released while idle
    assign scl_low = run && !quarter[1];

endmodule

// ==== common/i2c_pkg.sv ====
/*
 * Shared I2C master definitions: width typedefs, APB request/response
 * structs, command/result structs and register offsets
 */
package i2c_pkg;

    typedef logic [7:0] byte_t;      // One data byte on the bus
    typedef logic [6:0] i2c_addr_t;  // 7-bit target address
    typedef logic [7:0] apb_addr_t;  // APB byte address

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        logic [31:0] pwdata;
    } apb_req_t;                     // 43 bits

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;                     // 34 bits

    typedef struct packed {
        i2c_addr_t target;
        logic      rw;               // 1 = read
        byte_t     tx_data;
    } i2c_cmd_t;                     // 16 bits

    typedef struct packed {
        byte_t rx_data;
        logic  nack;
    } i2c_result_t;                  // 9 bits

    localparam apb_addr_t REG_CTRL   = 8'h00;  // start, rw, target
    localparam apb_addr_t REG_TXDATA = 8'h04;
    localparam apb_addr_t REG_RXDATA = 8'h08;  // Read-only
    localparam apb_addr_t REG_STATUS = 8'h0C;  // Read-only busy, done and nack

endpackage
